//--- testbench/loader_input.txt
# Downloads: test name index sparse, then fill count value or bytes count values, then end
# Checks: mem addr count values, writes count, cart id exrom game, bank type num laddr size addr
test prg_basic 04 0
bytes 10 01 08 0B 08 0A 00 9E 32 30 36
end
mem 801 8 0B 08 0A 00 9E 32 30 36
mem 2B 8 01 08 09 08 09 08 09 08
mem AC 4 00 00 09 08
writes 20
done
test crt_two_packets 05 0
fill 22 00
bytes 4 00 05 00 01
fill 38 00
bytes 20 43 48 49 50 00 00 00 14 00 00 00 00 80 00 20 00 A1 A2 A3 A4
bytes 19 43 48 49 50 00 00 00 13 00 01 00 01 A0 00 20 00 B1 B2 B3
end
bank 00 0000 8000 2000 100000
bank 01 0001 A000 2000 102000
mem 100000 4 A1 A2 A3 A4
mem 102000 3 B1 B2 B3
writes 7
cart 0005 00 01
attached 1
done
test prg_sparse_slots 04 1
bytes 6 00 C0 DE AD BE EF
end
mem C000 4 DE AD BE EF
mem 2B 8 01 08 04 C0 04 C0 04 C0
mem AC 4 00 00 04 C0
writes 16
done

//--- all.f
common/c64_mem_pkg.sv
common/loader_pkg.sv
common/mem_req_if.sv
hw/loader/dl_decode.sv
hw/loader/load_sequencer.sv
hw/loader/mem_slot.sv
hw/c64_loader.sv
testbench/tb_c64_loader.sv

//--- Makefile
TOOL       = verilator
TOP        = tb_c64_loader
FLIST      = all.f
OBJ_DIR    = obj_dir
VFLAGS     = --binary --timing --assert -Wno-fatal --top-module $(TOP)
LINT_FLAGS = --lint-only --timing -Wall --top-module $(TOP)
PASS_MSG   = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(VFLAGS) -f $(FLIST) -Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_c64_loader.sv
// Testbench for the program and cartridge loader
// Streams downloads from a data file and checks memory writes,
// BASIC pointers and cartridge header fields

module tb_c64_loader
	import loader_pkg::*;
	import c64_mem_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ADDR_W       = MEM_ADDR_W;
	localparam int RESET_CYCLES = 16;
	localparam int BYTE_CYCLES  = 40;
	localparam int WALK_CYCLES  = 300;

	logic              clk_sys;
	logic              reset_n;
	logic              dl_active_i;
	dl_index_t         dl_index_i;
	logic              dl_wr_i;
	logic [ADDR_W-1:0] dl_addr_i;
	mem_byte_t         dl_data_i;
	logic              dl_wait_o;
	logic              io_cycle_i;
	logic              mem_ce_o;
	logic              mem_we_o;
	logic [ADDR_W-1:0] mem_addr_o;
	mem_byte_t         mem_data_o;
	cart_word_t        cart_id_o;
	mem_byte_t         cart_exrom_o;
	mem_byte_t         cart_game_o;
	mem_byte_t         bank_type_o;
	cart_word_t        bank_num_o;
	cart_word_t        bank_laddr_o;
	cart_word_t        bank_size_o;
	logic [ADDR_W-1:0] bank_addr_o;
	logic              bank_wr_o;
	logic              cart_attached_o;

	integer            seed = 32'hb658_cf5e;
	logic              sparse;
	string             test_name;
	dl_index_t         cur_index;
	logic [ADDR_W-1:0] offset;
	int                test_errors;
	int                pass_cnt;
	int                fail_cnt;
	int                write_cnt;
	int                budget = RESET_CYCLES + 100;
	logic              we_prev;
	mem_byte_t         mem_model [logic [ADDR_W-1:0]];
	logic [80:0]       bank_seen [$];

	c64_loader i_c64_loader (.*);

	initial begin : clock_gen
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// Random free slots of at least two cycles
	initial begin : slot_gen
		int hi;
		int lo;
		logic [31:0] r;
		io_cycle_i = 1'b1;
		@(posedge clk_sys);
		forever begin
			r = $random(seed);
			hi = sparse ? 10 + int'(r[3:0]) : 1 + int'(r[2:0]);
			lo = 2 + int'(r[8]);
			io_cycle_i <= 1'b1;
			repeat (hi) @(posedge clk_sys);
			io_cycle_i <= 1'b0;
			repeat (lo) @(posedge clk_sys);
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		forever begin
			@(posedge clk_sys);
			cycles++;
			if (cycles > budget) begin
				$display("Timeout: the run took more than %0d cycles", budget);
				$display("Simulation finished: FAIL");
				$finish;
			end
		end
	end

	// ====================
	// Memory model
	// ====================
	always @(negedge clk_sys) begin
		if (reset_n) begin
			assert (mem_ce_o == mem_we_o) else begin
				$display("%s: mem_ce_o does not match mem_we_o", test_name);
				test_errors++;
			end
			if (mem_we_o) begin
				mem_model[mem_addr_o] = mem_data_o;
				assert (dl_wait_o) else begin
					$display("%s: write at %h while the host was not held", test_name, mem_addr_o);
					test_errors++;
				end
				if (!we_prev) begin
					write_cnt++;
					assert (!io_cycle_i) else begin
						$display("%s: write at %h started outside a free slot", test_name,
							mem_addr_o);
						test_errors++;
					end
				end
			end
			we_prev = mem_we_o;
			if (bank_wr_o)
				bank_seen.push_back({bank_type_o, bank_num_o, bank_laddr_o, bank_size_o,
					bank_addr_o});
		end
	end

	task automatic check_value(input string what, input logic [80:0] expected,
		input logic [80:0] actual);
		assert (actual == expected) else begin
			$display("ERROR %s: %s expected %0h actual %0h", test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic finish_test();
		if (test_errors == 0) begin
			pass_cnt++;
			$display("test %s: ok", test_name);
		end else begin
			fail_cnt++;
			$display("test %s: %0d errors", test_name, test_errors);
		end
	endtask

	// ====================
	// Host model
	// ====================
	task automatic wait_idle();
		@(negedge clk_sys);
		while (dl_wait_o)
			@(negedge clk_sys);
	endtask

	task automatic start_download(input dl_index_t idx, input logic slow);
		mem_model.delete();
		bank_seen.delete();
		write_cnt = 0;
		test_errors = 0;
		offset = '0;
		cur_index = idx;
		@(posedge clk_sys);
		dl_index_i <= idx;
		dl_active_i <= 1'b1;
		sparse <= slow;
		repeat (2) @(posedge clk_sys);
	endtask

	// Event and request trail the strobe by two cycles
	task automatic send_byte(input mem_byte_t value);
		@(posedge clk_sys);
		dl_addr_i <= offset;
		dl_data_i <= value;
		dl_wr_i <= 1'b1;
		@(posedge clk_sys);
		dl_wr_i <= 1'b0;
		offset = offset + 1'b1;
		repeat (2) @(posedge clk_sys);
		wait_idle();
	endtask

	task automatic end_download();
		@(posedge clk_sys);
		dl_active_i <= 1'b0;
		repeat (3) @(posedge clk_sys);
		wait_idle();
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic run_file();
		int fd;
		int cnt;
		string tok;
		string rest;
		logic [31:0] a;
		logic [31:0] v;
		logic [31:0] e [5];
		logic [ADDR_W-1:0] addr;
		fd = $fopen("testbench/loader_input.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file");
			fail_cnt++;
			return;
		end
		while ($fscanf(fd, "%s", tok) == 1) begin
			if (tok.getc(0) == "#") begin
				void'($fgets(rest, fd));
			end else if (tok == "test") begin
				void'($fscanf(fd, "%s %h %d", test_name, v, cnt));
				start_download(v[7:0], cnt != 0);
			end else if (tok == "fill") begin
				void'($fscanf(fd, "%d %h", cnt, v));
				budget += cnt * BYTE_CYCLES;
				repeat (cnt) send_byte(v[7:0]);
			end else if (tok == "bytes") begin
				void'($fscanf(fd, "%d", cnt));
				budget += cnt * BYTE_CYCLES;
				repeat (cnt) begin
					void'($fscanf(fd, "%h", v));
					send_byte(v[7:0]);
				end
			end else if (tok == "end") begin
				if (cur_index == IDX_PRG)
					budget += WALK_CYCLES;
				end_download();
			end else if (tok == "mem") begin
				void'($fscanf(fd, "%h %d", a, cnt));
				for (int k = 0; k < cnt; k++) begin
					void'($fscanf(fd, "%h", v));
					addr = ADDR_W'(a + k);
					assert (mem_model.exists(addr)) else begin
						$display("%s: no write was seen at address %h", test_name, addr);
						test_errors++;
					end
					if (mem_model.exists(addr))
						check_value($sformatf("memory at %h", addr), v[7:0], mem_model[addr]);
				end
			end else if (tok == "writes") begin
				void'($fscanf(fd, "%d", cnt));
				check_value("write count", cnt, write_cnt);
			end else if (tok == "cart") begin
				void'($fscanf(fd, "%h %h %h", e[0], e[1], e[2]));
				check_value("cart_id_o", e[0][15:0], cart_id_o);
				check_value("cart_exrom_o", e[1][7:0], cart_exrom_o);
				check_value("cart_game_o", e[2][7:0], cart_game_o);
			end else if (tok == "bank") begin
				void'($fscanf(fd, "%h %h %h %h %h", e[0], e[1], e[2], e[3], e[4]));
				assert (bank_seen.size() != 0) else begin
					$display("%s: a bank strobe is missing", test_name);
					test_errors++;
				end
				if (bank_seen.size() != 0)
					check_value("bank record", {e[0][7:0], e[1][15:0], e[2][15:0], e[3][15:0],
						e[4][ADDR_W-1:0]}, bank_seen.pop_front());
			end else if (tok == "attached") begin
				void'($fscanf(fd, "%h", v));
				check_value("cart_attached_o", v[0], cart_attached_o);
			end else if (tok == "done") begin
				assert (bank_seen.size() == 0) else begin
					$display("%s: %0d bank strobes more than expected", test_name,
						bank_seen.size());
					test_errors++;
				end
				finish_test();
			end else begin
				$display("Unknown command %s in the stimulus file", tok);
				fail_cnt++;
			end
		end
		$fclose(fd);
	endtask

	initial begin : main
		reset_n = 1'b0;
		dl_active_i = 1'b0;
		dl_index_i = '0;
		dl_wr_i = 1'b0;
		dl_addr_i = '0;
		dl_data_i = '0;
		sparse = 1'b0;
		we_prev = 1'b0;
		test_errors = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		test_name = "reset";
		repeat (RESET_CYCLES - 1) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("mem_we_o", 0, {mem_ce_o, mem_we_o});
		check_value("bank_wr_o", 0, bank_wr_o);
		check_value("dl_wait_o", 0, dl_wait_o);
		check_value("cart_attached_o", 0, cart_attached_o);
		finish_test();
		@(posedge clk_sys);
		reset_n <= 1'b1;
		repeat (4) @(posedge clk_sys);
		run_file();
		$display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

//--- hw/c64_loader.sv
// Program and cartridge loader
// Turns a host byte stream into slotted memory writes

module c64_loader
	import loader_pkg::*;
	import c64_mem_pkg::*;
#(
	parameter int                ADDR_W   = MEM_ADDR_W,
	parameter logic [ADDR_W-1:0] CRT_BASE = c64_mem_pkg::CRT_BASE
) (
	input  logic              clk_sys,
	input  logic              reset_n,
	// Host download port
	input  logic              dl_active_i,
	input  dl_index_t         dl_index_i,
	input  logic              dl_wr_i,
	input  logic [ADDR_W-1:0] dl_addr_i,
	input  mem_byte_t         dl_data_i,
	output logic              dl_wait_o,
	// Memory side
	input  logic              io_cycle_i,
	output logic              mem_ce_o,
	output logic              mem_we_o,
	output logic [ADDR_W-1:0] mem_addr_o,
	output mem_byte_t         mem_data_o,
	// Cartridge header
	output cart_word_t        cart_id_o,
	output mem_byte_t         cart_exrom_o,
	output mem_byte_t         cart_game_o,
	output mem_byte_t         bank_type_o,
	output cart_word_t        bank_num_o,
	output cart_word_t        bank_laddr_o,
	output cart_word_t        bank_size_o,
	output logic [ADDR_W-1:0] bank_addr_o,
	output logic              bank_wr_o,
	output logic              cart_attached_o
);

	logic      ev_valid;
	load_ev_t  ev_kind;
	mem_byte_t ev_data;

	mem_req_if #(.ADDR_W(ADDR_W)) mem_req ();

	dl_decode #(
		.ADDR_W(ADDR_W)
	) i_dl_decode (
		.clk_sys         (clk_sys),
		.reset_n         (reset_n),
		.dl_active_i     (dl_active_i),
		.dl_index_i      (dl_index_i),
		.dl_wr_i         (dl_wr_i),
		.dl_addr_i       (dl_addr_i),
		.dl_data_i       (dl_data_i),
		.ev_valid_o      (ev_valid),
		.ev_kind_o       (ev_kind),
		.ev_data_o       (ev_data),
		.cart_id_o       (cart_id_o),
		.cart_exrom_o    (cart_exrom_o),
		.cart_game_o     (cart_game_o),
		.bank_type_o     (bank_type_o),
		.bank_num_o      (bank_num_o),
		.bank_laddr_o    (bank_laddr_o),
		.bank_size_o     (bank_size_o),
		.bank_wr_o       (bank_wr_o),
		.cart_attached_o (cart_attached_o)
	);

	load_sequencer #(
		.ADDR_W   (ADDR_W),
		.CRT_BASE (CRT_BASE)
	) i_load_sequencer (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.ev_valid_i  (ev_valid),
		.ev_kind_i   (ev_kind),
		.ev_data_i   (ev_data),
		.req_o       (mem_req.seq),
		.bank_addr_o (bank_addr_o),
		.wait_o      (dl_wait_o)
	);

	mem_slot #(
		.ADDR_W(ADDR_W)
	) i_mem_slot (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.io_cycle_i (io_cycle_i),
		.req_i      (mem_req.slot),
		.mem_ce_o   (mem_ce_o),
		.mem_we_o   (mem_we_o),
		.mem_addr_o (mem_addr_o),
		.mem_data_o (mem_data_o)
	);

endmodule

//--- hw/loader/mem_slot.sv
// Memory slot block
// Puts the pending write on the memory bus for one free slot

module mem_slot
	import c64_mem_pkg::*;
#(
	parameter int ADDR_W = MEM_ADDR_W
) (
	input  logic              clk_sys,
	input  logic              reset_n,
	input  logic              io_cycle_i,
	mem_req_if.slot           req_i,
	output logic              mem_ce_o,
	output logic              mem_we_o,
	output logic [ADDR_W-1:0] mem_addr_o,
	output mem_byte_t         mem_data_o
);

	logic io_q;
	logic wr_act;
	logic done_q;
	logic slot_open;
	logic slot_close;
	logic start_wr;

	// io_cycle_i low means the slot belongs to the loader
	assign slot_open  = !io_cycle_i && io_q;
	assign slot_close = io_cycle_i && !io_q;
	// done_q blocks a second start before req has dropped
	assign start_wr   = slot_open && req_i.req && !done_q;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			io_q <= 1'b1;
			wr_act <= 1'b0;
			done_q <= 1'b0;
		end else begin
			io_q <= io_cycle_i;
			done_q <= 1'b0;
			if (start_wr)
				wr_act <= 1'b1;
			if (slot_close && wr_act) begin
				wr_act <= 1'b0;
				done_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (start_wr) begin
			mem_addr_o <= req_i.addr;
			mem_data_o <= req_i.data;
		end
	end

	assign mem_ce_o   = wr_act;
	assign mem_we_o   = wr_act;
	assign req_i.done = done_q;

endmodule

//--- hw/loader/load_sequencer.sv
// Load sequencer
// Keeps the load address and program end, runs the BASIC pointer
// walk after a PRG download and raises one write request at a time

module load_sequencer
	import loader_pkg::*;
	import c64_mem_pkg::*;
#(
	parameter int                ADDR_W   = MEM_ADDR_W,
	parameter logic [ADDR_W-1:0] CRT_BASE = c64_mem_pkg::CRT_BASE
) (
	input  logic              clk_sys,
	input  logic              reset_n,
	input  logic              ev_valid_i,
	input  load_ev_t          ev_kind_i,
	input  mem_byte_t         ev_data_i,
	mem_req_if.seq            req_o,
	output logic [ADDR_W-1:0] bank_addr_o,
	output logic              wait_o
);

	logic [ADDR_W-1:0] load_addr;
	logic [15:0]       prg_end;
	mem_byte_t         data_q;
	logic              req_q;
	logic              walk_q;
	logic              walk_end;
	logic              ptr_hit;
	mem_byte_t         ptr_val;

	assign walk_end = (load_addr == ADDR_W'(MEMINIT_END));

	// Pointer bytes that a BASIC LOAD would leave behind
	always_comb begin
		ptr_hit = 1'b1;
		ptr_val = SAVE_START_VAL;
		case (load_addr[7:0])
			PTR_TXT_LO: ptr_val = TXT_VAL_LO;
			PTR_TXT_HI: ptr_val = TXT_VAL_HI;
			PTR_SAVE_LO, PTR_SAVE_HI: ptr_val = SAVE_START_VAL;
			PTR_VAR_LO, PTR_ARY_LO, PTR_STR_LO, PTR_LEND_LO: ptr_val = prg_end[7:0];
			PTR_VAR_HI, PTR_ARY_HI, PTR_STR_HI, PTR_LEND_HI: ptr_val = prg_end[15:8];
			default: ptr_hit = 1'b0;
		endcase
	end

	// ====================
	// Address and request
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			req_q <= 1'b0;
			walk_q <= 1'b0;
			load_addr <= '0;
		end else begin
			if (req_o.done) begin
				req_q <= 1'b0;
				load_addr <= load_addr + 1'b1;
			end
			// One cycle per skipped address
			if (walk_q && !req_q) begin
				if (walk_end)
					walk_q <= 1'b0;
				else if (ptr_hit)
					req_q <= 1'b1;
				else
					load_addr <= load_addr + 1'b1;
			end
			if (ev_valid_i) begin
				case (ev_kind_i)
					EV_SET_LO: load_addr <= ADDR_W'(ev_data_i);
					EV_SET_HI: load_addr[15:8] <= ev_data_i;
					EV_CRT_START: load_addr <= CRT_BASE;
					EV_PKT_START: begin
						if (load_addr[CRT_ALIGN_W-1:0] != '0)
							load_addr <= {load_addr[ADDR_W-1:CRT_ALIGN_W] + 1'b1,
								{CRT_ALIGN_W{1'b0}}};
					end
					EV_DATA: req_q <= 1'b1;
					EV_PRG_END: begin
						walk_q <= 1'b1;
						load_addr <= '0;
					end
					default: ;
				endcase
			end
		end
	end

	// Write data and program end
	always_ff @(posedge clk_sys) begin
		if (ev_valid_i) begin
			case (ev_kind_i)
				EV_SET_LO: prg_end[7:0] <= ev_data_i;
				EV_SET_HI: prg_end[15:8] <= ev_data_i;
				EV_DATA: begin
					data_q <= ev_data_i;
					prg_end <= prg_end + 1'b1;
				end
				default: ;
			endcase
		end else if (walk_q && !req_q && !walk_end && ptr_hit) begin
			data_q <= ptr_val;
		end
	end

	assign req_o.req  = req_q;
	assign req_o.addr = load_addr;
	assign req_o.data = data_q;

	assign bank_addr_o = load_addr;
	// Host holds off while a write or the pointer walk is pending
	assign wait_o = req_q | walk_q;

endmodule

//--- hw/loader/dl_decode.sv
// Download stream decoder
// Classifies host bytes by index and offset into load events,
// tracks CRT chip packets and captures the cartridge header fields

module dl_decode
	import loader_pkg::*;
	import c64_mem_pkg::*;
#(
	parameter int ADDR_W = MEM_ADDR_W
) (
	input  logic              clk_sys,
	input  logic              reset_n,
	input  logic              dl_active_i,
	input  dl_index_t         dl_index_i,
	input  logic              dl_wr_i,
	input  logic [ADDR_W-1:0] dl_addr_i,
	input  mem_byte_t         dl_data_i,
	output logic              ev_valid_o,
	output load_ev_t          ev_kind_o,
	output mem_byte_t         ev_data_o,
	output cart_word_t        cart_id_o,
	output mem_byte_t         cart_exrom_o,
	output mem_byte_t         cart_game_o,
	output mem_byte_t         bank_type_o,
	output cart_word_t        bank_num_o,
	output cart_word_t        bank_laddr_o,
	output cart_word_t        bank_size_o,
	output logic              bank_wr_o,
	output logic              cart_attached_o
);

	logic        active_q;
	logic [3:0]  hdr_cnt;
	logic [31:0] blk_len;
	logic        is_prg;
	logic        is_crt;
	logic        pkt_area;
	logic        pkt_start;
	logic        in_hdr;
	logic        ev_hit;
	load_ev_t    ev_kind_d;

	assign is_prg = (dl_index_i[5:0] == IDX_PRG[5:0]) && (dl_index_i[7:6] == 2'b00);
	assign is_crt = (dl_index_i == IDX_CRT) || (dl_index_i == IDX_CRT_ALT);

	assign pkt_area  = is_crt && (dl_addr_i >= ADDR_W'(CRT_OFS_PKT));
	// Next chip packet begins once the previous block is used up
	assign pkt_start = pkt_area && (blk_len == '0) && (hdr_cnt == '0);
	assign in_hdr    = pkt_area && (hdr_cnt != '0);

	always_comb begin
		ev_hit = 1'b0;
		ev_kind_d = EV_DATA;
		if (active_q && !dl_active_i && is_prg) begin
			ev_hit = 1'b1;
			ev_kind_d = EV_PRG_END;
		end else if (dl_wr_i && is_prg) begin
			ev_hit = 1'b1;
			if (dl_addr_i == ADDR_W'(0))
				ev_kind_d = EV_SET_LO;
			else if (dl_addr_i == ADDR_W'(1))
				ev_kind_d = EV_SET_HI;
		end else if (dl_wr_i && is_crt) begin
			if (dl_addr_i == ADDR_W'(0)) begin
				ev_hit = 1'b1;
				ev_kind_d = EV_CRT_START;
			end else if (pkt_start) begin
				ev_hit = 1'b1;
				ev_kind_d = EV_PKT_START;
			end else if (pkt_area && !in_hdr) begin
				ev_hit = 1'b1;
			end
		end
	end

	// ====================
	// Control state
	// ====================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			active_q <= 1'b0;
			ev_valid_o <= 1'b0;
			bank_wr_o <= 1'b0;
			cart_attached_o <= 1'b0;
			hdr_cnt <= '0;
			blk_len <= '0;
		end else begin
			active_q <= dl_active_i;
			ev_valid_o <= ev_hit;
			bank_wr_o <= 1'b0;
			// Attached flag drops at CRT start and sets at CRT end
			if (is_crt && (active_q != dl_active_i))
				cart_attached_o <= active_q;
			if (dl_wr_i && is_crt) begin
				if (dl_addr_i == ADDR_W'(0)) begin
					hdr_cnt <= '0;
					blk_len <= '0;
				end else if (pkt_start) begin
					hdr_cnt <= 4'd1;
				end else if (in_hdr) begin
					hdr_cnt <= hdr_cnt + 1'b1;
					case (hdr_cnt)
						4'd4: blk_len[31:24] <= dl_data_i;
						4'd5: blk_len[23:16] <= dl_data_i;
						4'd6: blk_len[15:8] <= dl_data_i;
						4'd7: blk_len[7:0] <= dl_data_i;
						// Packet length includes its own header
						4'd8: blk_len <= blk_len - 32'(CRT_PKT_HDR_LEN);
						default: ;
					endcase
					if (hdr_cnt == 4'(CRT_PKT_HDR_LEN - 1))
						bank_wr_o <= 1'b1;
				end else if (pkt_area) begin
					blk_len <= blk_len - 1'b1;
				end
			end
		end
	end

	// Event payload and header fields
	always_ff @(posedge clk_sys) begin
		if (ev_hit) begin
			ev_kind_o <= ev_kind_d;
			ev_data_o <= dl_data_i;
		end
		if (dl_wr_i && is_crt) begin
			if (dl_addr_i == ADDR_W'(CRT_OFS_ID_HI))
				cart_id_o[15:8] <= dl_data_i;
			if (dl_addr_i == ADDR_W'(CRT_OFS_ID_LO))
				cart_id_o[7:0] <= dl_data_i;
			if (dl_addr_i == ADDR_W'(CRT_OFS_EXROM))
				cart_exrom_o <= dl_data_i;
			if (dl_addr_i == ADDR_W'(CRT_OFS_GAME))
				cart_game_o <= dl_data_i;
			if (in_hdr) begin
				case (hdr_cnt)
					4'd9:  bank_type_o <= dl_data_i;
					4'd10: bank_num_o[15:8] <= dl_data_i;
					4'd11: bank_num_o[7:0] <= dl_data_i;
					4'd12: bank_laddr_o[15:8] <= dl_data_i;
					4'd13: bank_laddr_o[7:0] <= dl_data_i;
					4'd14: bank_size_o[15:8] <= dl_data_i;
					4'd15: bank_size_o[7:0] <= dl_data_i;
					default: ;
				endcase
			end
		end
	end

endmodule

//--- common/mem_req_if.sv
// Pending memory write from the load sequencer to the slot block
// req is held, with addr and data stable, until done pulses

interface mem_req_if
	import c64_mem_pkg::*;
#(
	parameter int ADDR_W = MEM_ADDR_W
);

	logic              req;
	logic [ADDR_W-1:0] addr;
	mem_byte_t         data;
	logic              done;

	modport seq (output req, output addr, output data, input done);

	modport slot (input req, input addr, input data, output done);

endinterface

//--- common/loader_pkg.sv
// Loader package
// Download index codes, decode event kinds and CRT image layout

package loader_pkg;

	typedef logic [7:0] dl_index_t;
	typedef logic [15:0] cart_word_t;

	// Download index codes
	localparam dl_index_t IDX_PRG     = 8'h04;
	localparam dl_index_t IDX_CRT     = 8'h05;
	localparam dl_index_t IDX_CRT_ALT = 8'hC0;

	// Events passed from the byte decoder to the sequencer
	typedef enum logic [2:0] {
		EV_SET_LO,
		EV_SET_HI,
		EV_CRT_START,
		EV_PKT_START,
		EV_DATA,
		EV_PRG_END
	} load_ev_t;

	// CRT file header offsets
	localparam int unsigned CRT_OFS_ID_HI = 'h16;
	localparam int unsigned CRT_OFS_ID_LO = 'h17;
	localparam int unsigned CRT_OFS_EXROM = 'h18;
	localparam int unsigned CRT_OFS_GAME  = 'h19;
	localparam int unsigned CRT_OFS_PKT   = 'h40;

	localparam int unsigned CRT_PKT_HDR_LEN = 16;

endpackage

//--- common/c64_mem_pkg.sv
// Computer memory map package
// Memory widths, cartridge area and BASIC zero-page pointers

package c64_mem_pkg;

	localparam int MEM_ADDR_W = 25;

	typedef logic [7:0] mem_byte_t;

	// Cartridge payload area with packets on 8 KB boundaries
	localparam logic [MEM_ADDR_W-1:0] CRT_BASE = 25'h100000;
	localparam int CRT_ALIGN_W = 13;

	// Pointer walk stops here
	localparam int unsigned MEMINIT_END = 'h100;

	// ====================
	// BASIC pointers
	// ====================
	localparam mem_byte_t PTR_TXT_LO     = 8'h2B;
	localparam mem_byte_t PTR_TXT_HI     = 8'h2C;
	localparam mem_byte_t TXT_VAL_LO     = 8'h01;
	localparam mem_byte_t TXT_VAL_HI     = 8'h08;
	localparam mem_byte_t PTR_SAVE_LO    = 8'hAC;
	localparam mem_byte_t PTR_SAVE_HI    = 8'hAD;
	localparam mem_byte_t SAVE_START_VAL = 8'h00;
	// These follow the program end with the low byte first
	localparam mem_byte_t PTR_VAR_LO     = 8'h2D;
	localparam mem_byte_t PTR_VAR_HI     = 8'h2E;
	localparam mem_byte_t PTR_ARY_LO     = 8'h2F;
	localparam mem_byte_t PTR_ARY_HI     = 8'h30;
	localparam mem_byte_t PTR_STR_LO     = 8'h31;
	localparam mem_byte_t PTR_STR_HI     = 8'h32;
	localparam mem_byte_t PTR_LEND_LO    = 8'hAE;
	localparam mem_byte_t PTR_LEND_HI    = 8'hAF;

endpackage
